//--- comp_video_consts.svh
`ifndef COMP_VIDEO_CONSTS_SVH
`define COMP_VIDEO_CONSTS_SVH

// chip codes, bit 0 set selects PAL timing
`define CHIP_6567R8        2'd0
`define CHIP_6569R5        2'd1
`define CHIP_6567R56A      2'd2
`define CHIP_6569R1        2'd3

// raster_x values per line
`define LINE_LEN_6567R8    10'd520
`define LINE_LEN_6567R56A  10'd512
`define LINE_LEN_6569      10'd504

// horizontal timing in raster_x units
`define HSYNC_START_NTSC   10'd8
`define HSYNC_START_PAL    10'd7
`define HSYNC_WIDTH        10'd37
// measured from hsync start
`define ACTIVE_OFFSET_NTSC 10'd88
`define ACTIVE_OFFSET_PAL  10'd84
// from hsync end to first burst sample
`define BURST_DELAY        10'd5

// last visible line before the vertical blank
`define VVISIBLE_END_NTSC  9'd13
`define VVISIBLE_END_PAL   9'd300
// vblank_line code for lines outside the vertical blank
`define VBLANK_NONE        4'd15

// equalization tip and serration gap widths
`define EQ_WIDTH           10'd18
`define SERR_GAP           10'd37

// nine subcarrier cycles of sixteen samples
`define BURST_SAMPLES      8'd144
`define NO_MODULATION      4'd0
`define CHROMA_CENTER      6'd32
`define BURST_PHASE_NTSC     8'd128
`define BURST_PHASE_PAL_EVEN 8'd96
`define BURST_PHASE_PAL_ODD  8'd160

`endif

//--- comp_video_pkg.sv
package comp_video_pkg;

    // sine rom address
    // the modulator fills in amplitude and phase separately,
    // the rom only sees one flat 12 bit index
    // amplitude selects one of sixteen scaled sine tables
    // phase walks through 256 entries of one period
    typedef union packed {
        struct packed {
            // table select, 0 means no modulation
            logic [3:0] amplitude;
            // position within one subcarrier period
            logic [7:0] phase;
        } fields;
        // flat view used for the table read
        logic [11:0] index;
    } rom_addr_u;

endpackage : comp_video_pkg

//--- raster_sync_gen.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module raster_sync_gen (
    input  logic       clk_col16x,
    input  logic       rst_n,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_y,
    input  logic [1:0] chip,
    output logic       hsync,
    output logic       vsync,
    output logic       active,
    output logic [3:0] vblank_line,
    output logic       eq_tip,
    output logic       serr_tip,
    output logic       odd_line,
    output logic [9:0] burst_start_x
);

    logic       is_pal;
    logic [9:0] line_len;
    logic [9:0] hsync_start;
    logic [9:0] hsync_end;
    logic [9:0] hvisible_start;
    logic [9:0] half_x;
    logic [8:0] vvisible_end;
    logic [8:0] vblank_start;
    logic [8:0] vblank_end;
    logic [3:0] vblank_index;
    logic       in_vblank;
    logic       in_vborder;
    logic       eq_now;
    logic       serr_now;

    assign is_pal = (chip == `CHIP_6569R1) || (chip == `CHIP_6569R5);

    // line length per chip
    always_comb
    begin
        case (chip)
            `CHIP_6567R8:   line_len = `LINE_LEN_6567R8;
            `CHIP_6567R56A: line_len = `LINE_LEN_6567R56A;
            // both PAL revisions share one line length
            default:        line_len = `LINE_LEN_6569;
        endcase
    end

    // horizontal landmarks
    assign hsync_start    = is_pal ? `HSYNC_START_PAL : `HSYNC_START_NTSC;
    assign hsync_end      = hsync_start + `HSYNC_WIDTH;
    assign hvisible_start = hsync_start +
                            (is_pal ? `ACTIVE_OFFSET_PAL : `ACTIVE_OFFSET_NTSC);
    // second pulse of a vblank line sits half a line after hsync start
    assign half_x         = hsync_start + {1'b0, line_len[9:1]};

    // vertical landmarks, nine blank lines after the last visible one
    assign vvisible_end = is_pal ? `VVISIBLE_END_PAL : `VVISIBLE_END_NTSC;
    assign vblank_start = vvisible_end + 9'd1;
    assign vblank_end   = vvisible_end + 9'd9;
    assign in_vblank    = (raster_y >= vblank_start) && (raster_y <= vblank_end);
    assign in_vborder   = (raster_y >= vvisible_end) &&
                          (raster_y <= vvisible_end + 9'd10);
    // difference is below 16 so the low nibble is enough
    assign vblank_index = raster_y[3:0] - vblank_start[3:0];

    // short sync tips at both half-line points
    assign eq_now = ((raster_x >= hsync_start) &&
                     (raster_x < hsync_start + `EQ_WIDTH)) ||
                    ((raster_x >= half_x) && (raster_x < half_x + `EQ_WIDTH));

    // long tips, released a serration gap before the next half-line point
    assign serr_now = ((raster_x >= hsync_start) && (raster_x < half_x - `SERR_GAP)) ||
                      ((raster_x >= half_x) &&
                       (raster_x < hsync_start + line_len - `SERR_GAP));

    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hsync         <= 1'b0;
            vsync         <= 1'b0;
            active        <= 1'b0;
            vblank_line   <= `VBLANK_NONE;
            eq_tip        <= 1'b0;
            serr_tip      <= 1'b0;
            odd_line      <= 1'b0;
            burst_start_x <= 10'd0;
        end
        else
        begin
            hsync         <= (raster_x >= hsync_start) && (raster_x < hsync_end);
            vsync         <= in_vblank;
            // blank from x 0 until the visible start, and on the border lines
            active        <= (raster_x >= hvisible_start) && !in_vborder;
            vblank_line   <= in_vblank ? vblank_index : `VBLANK_NONE;
            eq_tip        <= eq_now;
            serr_tip      <= serr_now;
            odd_line      <= raster_y[0];
            burst_start_x <= hsync_end + `BURST_DELAY;
        end
    end

endmodule : raster_sync_gen

//--- luma_shaper.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module luma_shaper (
    input  logic       clk_col16x,
    input  logic       rst_n,
    input  logic       hsync,
    input  logic       active,
    input  logic [3:0] vblank_line,
    input  logic       eq_tip,
    input  logic       serr_tip,
    input  logic [5:0] pixel_luma,
    input  logic [5:0] blanking_level,
    output logic [5:0] luma
);

    logic       in_vblank;
    logic       use_serr;
    logic       vblank_tip;
    logic [5:0] vblank_luma;
    logic [5:0] target;
    logic [5:0] target_q;
    logic [5:0] hist1;
    logic [5:0] hist2;
    logic [5:0] hist3;
    logic [7:0] sum;

    assign in_vblank = (vblank_line != `VBLANK_NONE);

    // middle three vblank lines carry serration, the rest equalization
    assign use_serr    = (vblank_line >= 4'd3) && (vblank_line <= 4'd5);
    assign vblank_tip  = use_serr ? serr_tip : eq_tip;
    assign vblank_luma = vblank_tip ? 6'd0 : blanking_level;

    // sync tip, then blanking, then picture
    assign target = hsync ? 6'd0 : (active ? pixel_luma : blanking_level);

    // four sample running sum
    assign sum = {2'b00, target_q} + {2'b00, hist1} +
                 {2'b00, hist2} + {2'b00, hist3};

    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            target_q <= 6'd0;
            hist1    <= 6'd0;
            hist2    <= 6'd0;
            hist3    <= 6'd0;
            luma     <= 6'd0;
        end
        else
        begin
            target_q <= target;
            hist1    <= target_q;
            hist2    <= hist1;
            hist3    <= hist2;
            // vblank pulses bypass the averaging to keep sharp edges
            if (in_vblank)
                luma <= vblank_luma;
            else
                luma <= 6'(sum >> 2);
        end
    end

endmodule : luma_shaper

//--- chroma_modulator.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module chroma_modulator (
    input  logic                      clk_col16x,
    input  logic                      rst_n,
    input  logic                      vsync,
    input  logic                      active,
    input  logic                      odd_line,
    input  logic [9:0]                burst_start_x,
    input  logic [9:0]                raster_x,
    input  logic [8:0]                raster_y,
    input  logic [1:0]                chip,
    input  logic [7:0]                pixel_phase,
    input  logic [3:0]                pixel_amplitude,
    input  logic [3:0]                burst_amplitude,
    output comp_video_pkg::rom_addr_u rom_addr,
    output logic                      rom_enable
);

    logic       is_pal;
    logic [3:0] phase_count;
    logic [8:0] prev_raster_y;
    logic       burst_pending;
    logic       in_burst;
    logic [7:0] burst_count;
    logic [3:0] amplitude;
    logic [7:0] phase_offset;
    logic [7:0] phase;

    assign is_pal = (chip == `CHIP_6569R1) || (chip == `CHIP_6569R5);

    // sixteen samples per subcarrier period
    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
            phase_count <= 4'd0;
        else
            phase_count <= phase_count + 4'd1;
    end

    // burst armed by a new raster line, started at burst_start_x
    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prev_raster_y <= 9'd0;
            burst_pending <= 1'b0;
            in_burst      <= 1'b0;
            burst_count   <= 8'd0;
        end
        else
        begin
            prev_raster_y <= raster_y;
            if (in_burst)
            begin
                // last of the nine cycles
                if (burst_count == `BURST_SAMPLES - 8'd1)
                begin
                    in_burst    <= 1'b0;
                    burst_count <= 8'd0;
                end
                else
                    burst_count <= burst_count + 8'd1;
            end
            else if (burst_pending && (raster_x >= burst_start_x))
            begin
                in_burst      <= 1'b1;
                burst_pending <= 1'b0;
            end
            if (raster_y != prev_raster_y)
                burst_pending <= 1'b1;
        end
    end

    // vsync wins over picture, picture over burst
    always_comb
    begin
        if (vsync)
            amplitude = `NO_MODULATION;
        else if (active)
            amplitude = pixel_amplitude;
        else if (in_burst)
            amplitude = burst_amplitude;
        else
            amplitude = `NO_MODULATION;
    end

    always_comb
    begin
        if (active)
            // PAL odd lines mirror the phase, 256 minus p wraps in eight bits
            phase_offset = (is_pal && odd_line) ? 8'd0 - pixel_phase : pixel_phase;
        else if (is_pal)
            phase_offset = odd_line ? `BURST_PHASE_PAL_ODD : `BURST_PHASE_PAL_EVEN;
        else
            phase_offset = `BURST_PHASE_NTSC;
    end

    // counter gives the coarse position, offset shifts the whole wave
    assign phase = {phase_count, 4'b0000} + phase_offset;

    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rom_addr   <= '0;
            rom_enable <= 1'b0;
        end
        else
        begin
            rom_addr.fields.amplitude <= amplitude;
            rom_addr.fields.phase     <= phase;
            rom_enable                <= (amplitude != `NO_MODULATION);
        end
    end

endmodule : chroma_modulator

//--- sine_wave_rom.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module sine_wave_rom (
    input  logic                      clk_col16x,
    input  logic                      rst_n,
    input  comp_video_pkg::rom_addr_u rom_addr,
    input  logic                      rom_enable,
    output logic [5:0]                chroma
);

    // sixteen amplitude tables of 256 phase steps, centred on 256
    logic [8:0] sine_table [0:4095];
    logic [8:0] rom_data;
    logic       enable_q;

    initial
    begin : fill_table
        real two_pi;
        real wave;
        int  amp;
        int  ph;
        two_pi = 2.0 * 3.14159265358979;
        for (int i = 0; i < 4096; i++)
        begin
            amp  = i / 256;
            ph   = i % 256;
            wave = real'(amp) * 16.0 * $sin(two_pi * real'(ph) / 256.0);
            // $rtoi truncates toward zero, peak swing is 240
            sine_table[i] = 9'(256 + $rtoi(wave));
        end
    end

    // registered table read
    always_ff @(posedge clk_col16x)
    begin
        rom_data <= sine_table[rom_addr.index];
    end

    // enable delayed to line up with the read data
    always_ff @(posedge clk_col16x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            enable_q <= 1'b0;
            chroma   <= `CHROMA_CENTER;
        end
        else
        begin
            enable_q <= rom_enable;
            chroma   <= enable_q ? 6'(rom_data >> 3) : `CHROMA_CENTER;
        end
    end

endmodule : sine_wave_rom

//--- comp_video_top.sv
`timescale 1ns/1ps

module comp_video_top (
    input  logic       clk_col16x,
    input  logic       rst_n,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_y,
    input  logic [1:0] chip,
    input  logic [5:0] pixel_luma,
    input  logic [7:0] pixel_phase,
    input  logic [3:0] pixel_amplitude,
    input  logic [5:0] blanking_level,
    input  logic [3:0] burst_amplitude,
    output logic [5:0] luma,
    output logic [5:0] chroma
);

    // sync levels, one cycle after the raster inputs
    logic       hsync;
    logic       vsync;
    logic       active;
    logic [3:0] vblank_line;
    logic       eq_tip;
    logic       serr_tip;
    logic       odd_line;
    logic [9:0] burst_start_x;
    // modulator to rom
    comp_video_pkg::rom_addr_u rom_addr;
    logic                      rom_enable;

    raster_sync_gen u_sync (
        .clk_col16x (clk_col16x), .rst_n (rst_n),
        .raster_x (raster_x), .raster_y (raster_y), .chip (chip),
        .hsync (hsync), .vsync (vsync), .active (active),
        .vblank_line (vblank_line), .eq_tip (eq_tip), .serr_tip (serr_tip),
        .odd_line (odd_line), .burst_start_x (burst_start_x)
    );

    luma_shaper u_luma (
        .clk_col16x (clk_col16x), .rst_n (rst_n),
        .hsync (hsync), .active (active), .vblank_line (vblank_line),
        .eq_tip (eq_tip), .serr_tip (serr_tip),
        .pixel_luma (pixel_luma), .blanking_level (blanking_level),
        .luma (luma)
    );

    chroma_modulator u_chroma (
        .clk_col16x (clk_col16x), .rst_n (rst_n),
        .vsync (vsync), .active (active), .odd_line (odd_line),
        .burst_start_x (burst_start_x),
        .raster_x (raster_x), .raster_y (raster_y), .chip (chip),
        .pixel_phase (pixel_phase), .pixel_amplitude (pixel_amplitude),
        .burst_amplitude (burst_amplitude),
        .rom_addr (rom_addr), .rom_enable (rom_enable)
    );

    sine_wave_rom u_rom (
        .clk_col16x (clk_col16x), .rst_n (rst_n),
        .rom_addr (rom_addr), .rom_enable (rom_enable),
        .chroma (chroma)
    );

endmodule : comp_video_top

//--- comp_video_properties.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module comp_video_properties (
    input logic       clk_col16x,
    input logic       rst_n,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] vblank_line,
    input logic       rom_enable,
    input logic [5:0] luma,
    input logic [5:0] chroma
);

    // number of failed assertions
    int assert_errors = 0;

    // rom read plus output register
    disabled_rom_centres_chroma: assert property (@(posedge clk_col16x) disable iff (!rst_n)
        !rom_enable |-> ##2 (chroma == `CHROMA_CENTER))
        else
        begin
            assert_errors++;
            $error("chroma off centre two cycles after rom_enable low");
        end

    // four sync samples fill the averaging window
    hsync_gives_sync_level: assert property (@(posedge clk_col16x) disable iff (!rst_n)
        (hsync && (vblank_line == `VBLANK_NONE)) [*4] ##1 (vblank_line == `VBLANK_NONE)
        |-> ##1 (luma == 6'd0))
        else
        begin
            assert_errors++;
            $error("luma not at sync level inside hsync");
        end

    // modulator register, rom read, output register
    vsync_has_no_chroma: assert property (@(posedge clk_col16x) disable iff (!rst_n)
        vsync |-> ##3 (chroma == `CHROMA_CENTER))
        else
        begin
            assert_errors++;
            $error("chroma modulated during vsync");
        end

endmodule : comp_video_properties

//--- comp_video_tb.sv
`timescale 1ns/1ps
`include "comp_video_consts.svh"

module comp_video_tb;

    localparam int TEST_LINES  = 21;
    localparam int CYCLE_LIMIT = TEST_LINES * 520 + 2000;

    logic       clk_col16x;
    logic       rst_n;
    logic [9:0] raster_x;
    logic [8:0] raster_y;
    logic [1:0] chip;
    logic [5:0] pixel_luma;
    logic [7:0] pixel_phase;
    logic [3:0] pixel_amplitude;
    logic [5:0] blanking_level;
    logic [3:0] burst_amplitude;
    logic [5:0] luma;
    logic [5:0] chroma;

    // values driven by the next tick
    logic       rst_drive;
    logic [1:0] chip_sel;
    logic [5:0] px_luma;
    logic [7:0] px_phase;
    logic [3:0] px_amp;
    logic [5:0] blank_lvl;
    logic [3:0] burst_amp;

    // ring of the last sixteen driven cycles
    logic [9:0] hx [0:15];
    logic [8:0] hy [0:15];
    logic [1:0] hchip [0:15];
    logic [5:0] hluma [0:15];
    logic [5:0] hblank [0:15];
    logic [7:0] hphase [0:15];
    logic [3:0] hamp [0:15];
    logic [3:0] hburst [0:15];

    int         cyc;
    int         release_cyc;
    int         burst_d;
    int         wd_count;
    int         n_checks;
    int         err_luma;
    int         err_chroma;
    int         err_addr;
    logic [8:0] prev_y;
    logic       armed;
    logic       check_en;
    string      test_name;

    comp_video_top dut (
        .clk_col16x (clk_col16x), .rst_n (rst_n),
        .raster_x (raster_x), .raster_y (raster_y), .chip (chip),
        .pixel_luma (pixel_luma), .pixel_phase (pixel_phase),
        .pixel_amplitude (pixel_amplitude), .blanking_level (blanking_level),
        .burst_amplitude (burst_amplitude), .luma (luma), .chroma (chroma)
    );

    bind comp_video_top comp_video_properties props (
        .clk_col16x (clk_col16x), .rst_n (rst_n), .hsync (hsync), .vsync (vsync),
        .vblank_line (vblank_line), .rom_enable (rom_enable),
        .luma (luma), .chroma (chroma)
    );

    initial
    begin
        clk_col16x = 1'b0;
        forever #20 clk_col16x = ~clk_col16x;
    end

    // run limit
    always @(posedge clk_col16x)
    begin
        wd_count <= wd_count + 1;
        if (wd_count > CYCLE_LIMIT)
        begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int line_len_of(input logic [1:0] c);
        if (c == `CHIP_6567R8)
            return int'(`LINE_LEN_6567R8);
        else if (c == `CHIP_6567R56A)
            return int'(`LINE_LEN_6567R56A);
        return int'(`LINE_LEN_6569);
    endfunction

    function automatic int hs_of(input logic [1:0] c);
        return c[0] ? int'(`HSYNC_START_PAL) : int'(`HSYNC_START_NTSC);
    endfunction

    function automatic int vend_of(input logic [1:0] c);
        return c[0] ? int'(`VVISIBLE_END_PAL) : int'(`VVISIBLE_END_NTSC);
    endfunction

    function automatic logic is_active(input int x, input int y, input logic [1:0] c);
        int off;
        off = c[0] ? int'(`ACTIVE_OFFSET_PAL) : int'(`ACTIVE_OFFSET_NTSC);
        return (x >= hs_of(c) + off) && !((y >= vend_of(c)) && (y <= vend_of(c) + 10));
    endfunction

    // sync level of one driven cycle before averaging
    function automatic logic [5:0] target_at(input int d);
        logic [3:0] k;
        logic [3:0] p;
        int         x;
        k = 4'(d);
        p = 4'(d + 1);
        x = int'(hx[k]);
        if ((x >= hs_of(hchip[k])) && (x < hs_of(hchip[k]) + int'(`HSYNC_WIDTH)))
            return 6'd0;
        if (is_active(x, int'(hy[k]), hchip[k]))
            return hluma[p];
        return hblank[p];
    endfunction

    function automatic logic [5:0] expected_luma(input int c);
        logic [3:0] k;
        int         x;
        int         vi;
        int         hs;
        int         half;
        int         len;
        logic       tip;
        int         sum;
        k   = 4'(c - 2);
        x   = int'(hx[k]);
        hs  = hs_of(hchip[k]);
        len = line_len_of(hchip[k]);
        half = hs + len / 2;
        vi  = int'(hy[k]) - vend_of(hchip[k]) - 1;
        if ((vi >= 0) && (vi <= 8))
        begin
            // serration on the middle three lines, equalization elsewhere
            if ((vi >= 3) && (vi <= 5))
                tip = ((x >= hs) && (x < half - int'(`SERR_GAP))) ||
                      ((x >= half) && (x < hs + len - int'(`SERR_GAP)));
            else
                tip = ((x >= hs) && (x < hs + int'(`EQ_WIDTH))) ||
                      ((x >= half) && (x < half + int'(`EQ_WIDTH)));
            return tip ? 6'd0 : hblank[4'(c - 1)];
        end
        sum = int'(target_at(c - 3)) + int'(target_at(c - 4)) +
              int'(target_at(c - 5)) + int'(target_at(c - 6));
        return 6'(sum / 4);
    endfunction

    // address formed on edge f
    function automatic comp_video_pkg::rom_addr_u expected_addr(input int f);
        logic [3:0]                d;
        logic [3:0]                p;
        int                        x;
        int                        y;
        logic [1:0]                c;
        logic                      odd;
        logic                      act;
        logic [3:0]                amp;
        int                        off;
        int                        cnt;
        comp_video_pkg::rom_addr_u a;
        d   = 4'(f - 2);
        p   = 4'(f - 1);
        x   = int'(hx[d]);
        y   = int'(hy[d]);
        c   = hchip[d];
        odd = hy[d][0];
        act = is_active(x, y, c);
        if ((y >= vend_of(c) + 1) && (y <= vend_of(c) + 9))
            amp = `NO_MODULATION;
        else if (act)
            amp = hamp[p];
        else if ((f - 2 - burst_d >= 0) && (f - 2 - burst_d < int'(`BURST_SAMPLES)))
            amp = hburst[p];
        else
            amp = `NO_MODULATION;
        if (act)
            off = (c[0] && odd) ? 256 - int'(hphase[p]) : int'(hphase[p]);
        else if (c[0])
            off = odd ? int'(`BURST_PHASE_PAL_ODD) : int'(`BURST_PHASE_PAL_EVEN);
        else
            off = int'(`BURST_PHASE_NTSC);
        cnt = (f - release_cyc - 1) % 16;
        a.fields.amplitude = amp;
        a.fields.phase     = 8'((cnt * 16 + off) % 256);
        return a;
    endfunction

    // entry = 256 + trunc(amplitude * 16 * sin), chroma is its top six bits
    function automatic logic [5:0] chroma_of(input comp_video_pkg::rom_addr_u a);
        real w;
        int  e;
        if (a.fields.amplitude == `NO_MODULATION)
            return `CHROMA_CENTER;
        w = real'(int'(a.fields.amplitude)) * 16.0 *
            $sin(2.0 * 3.14159265358979 * real'(int'(a.fields.phase)) / 256.0);
        e = 256 + $rtoi(w);
        return 6'(e / 8);
    endfunction

    task automatic compare_luma(input logic [5:0] exp, input logic [5:0] act);
        n_checks++;
        if (exp !== act)
        begin
            err_luma++;
            $display("error %s: luma expected %0d actual %0d (cycle %0d)",
                     test_name, exp, act, cyc);
        end
    endtask

    task automatic compare_chroma(input logic [5:0] exp, input logic [5:0] act);
        n_checks++;
        if (exp !== act)
        begin
            err_chroma++;
            $display("error %s: chroma expected %0d actual %0d (cycle %0d)",
                     test_name, exp, act, cyc);
        end
    endtask

    task automatic compare_rom_addr(input comp_video_pkg::rom_addr_u exp,
                                    input comp_video_pkg::rom_addr_u act);
        n_checks++;
        if (exp !== act)
        begin
            err_addr++;
            $display("error %s: rom_addr expected %03h actual %03h (cycle %0d)",
                     test_name, exp.index, act.index, cyc);
        end
    endtask

    // one clock: drive on the rising edge, check on the falling edge
    task automatic tick(input logic [9:0] x, input logic [8:0] y);
        logic [3:0] k;
        @(posedge clk_col16x);
        cyc++;
        k = 4'(cyc);
        rst_n           <= rst_drive;
        raster_x        <= x;
        raster_y        <= y;
        chip            <= chip_sel;
        pixel_luma      <= px_luma;
        pixel_phase     <= px_phase;
        pixel_amplitude <= px_amp;
        blanking_level  <= blank_lvl;
        burst_amplitude <= burst_amp;
        hx[k]     = x;
        hy[k]     = y;
        hchip[k]  = chip_sel;
        hluma[k]  = px_luma;
        hblank[k] = blank_lvl;
        hphase[k] = px_phase;
        hamp[k]   = px_amp;
        hburst[k] = burst_amp;
        // a new line arms the burst, it starts at hsync end plus the delay
        if (y != prev_y)
            armed = 1'b1;
        prev_y = y;
        if (armed && (int'(x) >= hs_of(chip_sel) + int'(`HSYNC_WIDTH) + int'(`BURST_DELAY)))
        begin
            burst_d = cyc;
            armed   = 1'b0;
        end
        @(negedge clk_col16x);
        if (check_en && (cyc - release_cyc >= 8))
        begin
            compare_luma(expected_luma(cyc), luma);
            compare_chroma(chroma_of(expected_addr(cyc - 2)), chroma);
            compare_rom_addr(expected_addr(cyc), dut.rom_addr);
        end
    endtask

    // raster_x through one whole line, wrapping to 0 on the next call
    task automatic advance_line(input logic [8:0] y, input int step_x, input logic [5:0] b);
        for (int x = 0; x < line_len_of(chip_sel); x++)
        begin
            if (x == step_x)
                px_luma = b;
            tick(10'(x), y);
        end
    endtask

    task automatic switch_chip(input logic [1:0] c);
        check_en = 1'b0;
        chip_sel = c;
        repeat (8) tick(10'd0, prev_y);
        check_en = 1'b1;
    endtask

    task automatic test_reset_state();
        test_name = "reset";
        repeat (4)
        begin
            tick(10'd0, 9'd0);
            compare_luma(6'd0, luma);
            compare_chroma(`CHROMA_CENTER, chroma);
        end
        rst_drive = 1'b1;
        tick(10'd0, 9'd0);
        release_cyc = cyc;
        compare_luma(6'd0, luma);
        compare_chroma(`CHROMA_CENTER, chroma);
        repeat (10) tick(10'd0, 9'd0);
        check_en = 1'b1;
    endtask

    task automatic test_horizontal();
        test_name = "horizontal";
        px_luma   = 6'($urandom_range(30, 63));
        advance_line(9'd40, -1, 6'd0);
    endtask

    task automatic test_vsync_pulses();
        test_name = "vsync_pulses";
        for (int y = 13; y <= 23; y++)
            advance_line(9'(y), -1, 6'd0);
    endtask

    // step from a low level to a high one inside the active area
    task automatic test_averaging();
        test_name = "averaging";
        px_luma   = 6'($urandom_range(0, 31));
        advance_line(9'd41, 300, 6'($urandom_range(32, 63)));
    endtask

    task automatic test_ntsc_chroma();
        test_name = "ntsc_chroma";
        px_phase  = 8'($urandom_range(0, 255));
        px_amp    = 4'($urandom_range(1, 15));
        advance_line(9'd42, -1, 6'd0);
        px_amp    = `NO_MODULATION;
        advance_line(9'd43, -1, 6'd0);
    endtask

    task automatic test_burst_pal();
        test_name = "burst_ntsc";
        // border line, burst window fully outside the active area
        advance_line(9'd13, -1, 6'd0);
        switch_chip(`CHIP_6569R5);
        test_name = "burst_pal";
        // away from 0 and 128 so the odd line mirror moves the phase
        px_phase  = 8'($urandom_range(1, 127));
        px_amp    = 4'($urandom_range(1, 15));
        advance_line(9'd298, -1, 6'd0);
        advance_line(9'd299, -1, 6'd0);
        advance_line(9'd300, -1, 6'd0);
        advance_line(9'd305, -1, 6'd0);
        advance_line(9'd311, -1, 6'd0);
    endtask

    initial
    begin
        void'($urandom(18953));
        rst_n = 1'b0;
        raster_x = 10'd0;
        raster_y = 9'd0;
        chip = `CHIP_6567R8;
        pixel_luma = 6'd0;
        pixel_phase = 8'd0;
        pixel_amplitude = 4'd0;
        blanking_level = 6'd0;
        burst_amplitude = 4'd0;
        rst_drive = 1'b0;
        chip_sel = `CHIP_6567R8;
        px_luma = 6'd0;
        px_phase = 8'd0;
        px_amp = 4'd0;
        blank_lvl = 6'($urandom_range(8, 20));
        burst_amp = 4'($urandom_range(4, 15));
        cyc = 0;
        release_cyc = 0;
        burst_d = -1000;
        wd_count = 0;
        n_checks = 0;
        err_luma = 0;
        err_chroma = 0;
        err_addr = 0;
        prev_y = 9'd0;
        armed = 1'b0;
        check_en = 1'b0;
        test_reset_state();
        test_horizontal();
        test_vsync_pulses();
        test_averaging();
        test_ntsc_chroma();
        test_burst_pal();
        $display("summary: %0d checks, errors luma %0d chroma %0d rom_addr %0d assertions %0d",
                 n_checks, err_luma, err_chroma, err_addr, dut.props.assert_errors);
        if (err_luma + err_chroma + err_addr + dut.props.assert_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule : comp_video_tb

//--- compile.f
+incdir+.
comp_video_pkg.sv
raster_sync_gen.sv
luma_shaper.sv
chroma_modulator.sv
sine_wave_rom.sv
comp_video_top.sv
comp_video_properties.sv
comp_video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := comp_video_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
